// File: rx_pcs_lanes.f
+incdir+sim
source/rx_pcs_pkg.sv
source/block_decoder.sv
source/frame_sequence_check.sv
source/xgmii_rx_output.sv
source/rx_cfg_regs.sv
source/rx_pcs_lanes.sv
sim/rx_pcs_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rx_pcs_lanes testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module rx_pcs_tb -f rx_pcs_lanes.f \
    && ./obj_dir/Vrx_pcs_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

// File: sim/rx_pcs_model.svh
`ifndef RX_PCS_MODEL_SVH
`define RX_PCS_MODEL_SVH

logic                            model_in_frame;
logic                            model_bypass;
logic [rx_pcs_pkg::ERRCNT_W-1:0] model_errcnt;
int                              lane_errors;
int                              flag_errors;
int                              reg_errors;

//////////////////////////////////////////////////
// Block decode
//////////////////////////////////////////////////

function automatic void decode_block(
    input  logic [rx_pcs_pkg::HDR_W-1:0]  hdr,
    input  logic [rx_pcs_pkg::DATA_W-1:0] payload,
    output logic [rx_pcs_pkg::DATA_W-1:0] rxd,
    output logic [rx_pcs_pkg::CTRL_W-1:0] rxc,
    output logic [rx_pcs_pkg::KIND_W-1:0] kind
);
    rx_pcs_pkg::block_payload_u blk;
    rx_pcs_pkg::block_payload_u xg;
    blk  = payload;
    xg   = {8{rx_pcs_pkg::XG_ERROR}};
    rxc  = '1;
    kind = rx_pcs_pkg::KIND_BAD;
    if (hdr == rx_pcs_pkg::SYNC_DATA) begin
        xg   = blk;
        rxc  = '0;
        kind = rx_pcs_pkg::KIND_DATA;
    end else if (hdr == rx_pcs_pkg::SYNC_CTRL) begin
        case (blk.ctl.block_type)
            rx_pcs_pkg::BT_IDLE: begin
                xg   = {8{rx_pcs_pkg::XG_IDLE}};
                kind = rx_pcs_pkg::KIND_IDLE;
            end
            rx_pcs_pkg::BT_START: begin
                xg         = blk;
                xg.data[0] = rx_pcs_pkg::XG_START;
                rxc        = 8'h01;
                kind       = rx_pcs_pkg::KIND_START;
            end
            rx_pcs_pkg::BT_TERM7: begin
                // Bytes 1..7 on the wire become D0..D6
                for (int b = 0; b < 7; b++) begin
                    xg.data[b] = blk.data[b+1];
                end
                xg.data[7] = rx_pcs_pkg::XG_TERM;
                rxc        = 8'h80;
                kind       = rx_pcs_pkg::KIND_TERM;
            end
            rx_pcs_pkg::BT_TERM0: begin
                xg         = {8{rx_pcs_pkg::XG_IDLE}};
                xg.data[0] = rx_pcs_pkg::XG_TERM;
                kind       = rx_pcs_pkg::KIND_TERM;
            end
            default: ;
        endcase
    end
    rxd = xg;
endfunction

// Frame order, error substitution, bypass and counter for one lane
function automatic void model_lane(
    input  logic [rx_pcs_pkg::HDR_W-1:0]  hdr,
    input  logic [rx_pcs_pkg::DATA_W-1:0] payload,
    output logic [rx_pcs_pkg::DATA_W-1:0] rxd,
    output logic [rx_pcs_pkg::CTRL_W-1:0] rxc
);
    logic [rx_pcs_pkg::DATA_W-1:0] dec_d;
    logic [rx_pcs_pkg::CTRL_W-1:0] dec_c;
    logic [rx_pcs_pkg::KIND_W-1:0] kind;
    logic                          err;
    decode_block(hdr, payload, dec_d, dec_c, kind);
    if (kind == rx_pcs_pkg::KIND_BAD) begin
        err = 1'b1;
    end else if (model_in_frame) begin
        err = (kind == rx_pcs_pkg::KIND_START) || (kind == rx_pcs_pkg::KIND_IDLE);
    end else begin
        err = (kind == rx_pcs_pkg::KIND_DATA) || (kind == rx_pcs_pkg::KIND_TERM);
    end
    model_in_frame = !err &&
                     ((kind == rx_pcs_pkg::KIND_START) || (kind == rx_pcs_pkg::KIND_DATA));
    rxd = dec_d;
    rxc = dec_c;
    if (model_bypass) begin
        rxd = payload;
        rxc = '0;
    end else if (err) begin
        rxd = {8{rx_pcs_pkg::XG_ERROR}};
        rxc = '1;
        if (model_errcnt != rx_pcs_pkg::ERRCNT_MAX) begin
            model_errcnt = model_errcnt + 1'b1;
        end
    end
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic check_lane(
    input string                         name,
    input logic [rx_pcs_pkg::DATA_W-1:0] exp_rxd,
    input logic [rx_pcs_pkg::CTRL_W-1:0] exp_rxc,
    input logic [rx_pcs_pkg::DATA_W-1:0] act_rxd,
    input logic [rx_pcs_pkg::CTRL_W-1:0] act_rxc
);
    if (act_rxd !== exp_rxd || act_rxc !== exp_rxc) begin
        lane_errors++;
        $display("Error %s: expected rxd %h rxc %h, actual rxd %h rxc %h",
                 name, exp_rxd, exp_rxc, act_rxd, act_rxc);
    end
endtask

task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        flag_errors++;
        $display("Error %s: expected valid %b, actual valid %b", name, expected, actual);
    end
endtask

task automatic check_count(
    input string                             name,
    input logic [rx_pcs_pkg::REG_DATA_W-1:0] expected,
    input logic [rx_pcs_pkg::REG_DATA_W-1:0] actual
);
    if (actual !== expected) begin
        reg_errors++;
        $display("Error %s: expected register %0d, actual register %0d",
                 name, expected, actual);
    end
endtask

`endif

// File: sim/rx_pcs_tb.sv
module rx_pcs_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RANDOM_CYCLES  = 600;
    localparam int SHORT_CYCLES   = 100;
    // Three times the traffic, plus reset, drains and register accesses
    localparam int TIMEOUT_CYCLES = 3 * (RANDOM_CYCLES + 3 * SHORT_CYCLES) + 300;
    localparam int MODE_MIXED     = 0;
    localparam int MODE_BAD       = 1;

    logic                                                      rx_clk_161_13;
    logic                                                      async_reset_n;
    logic                                                      block_valid_i;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::HDR_W-1:0]  rx_header_i;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] rx_data_i;
    logic                                                      reg_req_i;
    logic                                                      reg_we_i;
    logic [rx_pcs_pkg::REG_ADDR_W-1:0]                         reg_addr_i;
    logic [rx_pcs_pkg::REG_DATA_W-1:0]                         reg_wdata_i;
    logic                                                      xgmii_valid_o;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] xgmii_rxd_o;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::CTRL_W-1:0] xgmii_rxc_o;
    logic                                                      reg_ack_o;
    logic [rx_pcs_pkg::REG_DATA_W-1:0]                         reg_rdata_o;

    logic                                                      exp_valid;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] exp_rxd;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::CTRL_W-1:0] exp_rxc;
    logic                                                      gen_in_frame;
    int                                                        gen_data_left;
    int                                                        cycle_count;
    string                                                     test_name;

    `include "rx_pcs_model.svh"

    rx_pcs_lanes u_dut (.*);

    initial begin
        rx_clk_161_13 = 1'b0;
        forever #10 rx_clk_161_13 = ~rx_clk_161_13;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge rx_clk_161_13);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Block stream generator
    //////////////////////////////////////////////////

    task automatic make_block(
        input  int                            mode,
        output logic [rx_pcs_pkg::HDR_W-1:0]  hdr,
        output logic [rx_pcs_pkg::DATA_W-1:0] payload
    );
        rx_pcs_pkg::block_payload_u blk;
        logic [7:0]                 bad_type;
        int                         r;
        blk = {$urandom, $urandom};
        hdr = rx_pcs_pkg::SYNC_CTRL;
        r   = $urandom_range(31);
        if (mode == MODE_BAD || r == 0) begin
            hdr = $urandom_range(1) ? 2'b00 : 2'b11;
        end else if (r == 1) begin
            do begin
                bad_type = 8'($urandom);
            end while (bad_type == rx_pcs_pkg::BT_IDLE || bad_type == rx_pcs_pkg::BT_START ||
                       bad_type == rx_pcs_pkg::BT_TERM7 || bad_type == rx_pcs_pkg::BT_TERM0);
            blk.ctl.block_type = bad_type;
        end else if (r == 2) begin
            // Misordered block for the current frame state
            if (gen_in_frame) begin
                blk.ctl.block_type = $urandom_range(1) ? rx_pcs_pkg::BT_START : rx_pcs_pkg::BT_IDLE;
            end else if ($urandom_range(1)) begin
                hdr = rx_pcs_pkg::SYNC_DATA;
            end else begin
                blk.ctl.block_type = rx_pcs_pkg::BT_TERM7;
            end
        end else if (!gen_in_frame) begin
            blk.ctl.block_type = rx_pcs_pkg::BT_IDLE;
            if ($urandom_range(2) == 0) begin
                blk.ctl.block_type = rx_pcs_pkg::BT_START;
                gen_in_frame       = 1'b1;
                gen_data_left      = $urandom_range(10);
            end
        end else if (gen_data_left > 0) begin
            hdr = rx_pcs_pkg::SYNC_DATA;
            gen_data_left--;
        end else begin
            blk.ctl.block_type = $urandom_range(1) ? rx_pcs_pkg::BT_TERM7 : rx_pcs_pkg::BT_TERM0;
            gen_in_frame       = 1'b0;
        end
        payload = blk;
    endtask

    // Check the set registered at this edge, then drive the next one
    task automatic step(input logic valid, input int mode);
        logic [rx_pcs_pkg::HDR_W-1:0]  hdr;
        logic [rx_pcs_pkg::DATA_W-1:0] payload;
        @(posedge rx_clk_161_13);
        #2;
        check_valid(test_name, exp_valid, xgmii_valid_o);
        for (int i = 0; i < rx_pcs_pkg::NUM_LANES; i++) begin
            if (exp_valid) begin
                check_lane($sformatf("%s lane %0d", test_name, i),
                           exp_rxd[i], exp_rxc[i], xgmii_rxd_o[i], xgmii_rxc_o[i]);
            end
        end
        block_valid_i = valid;
        exp_valid     = valid;
        for (int i = 0; i < rx_pcs_pkg::NUM_LANES; i++) begin
            hdr     = 2'($urandom);
            payload = {$urandom, $urandom};
            if (valid) begin
                make_block(mode, hdr, payload);
                model_lane(hdr, payload, exp_rxd[i], exp_rxc[i]);
            end
            rx_header_i[i] = hdr;
            rx_data_i[i]   = payload;
        end
    endtask

    task automatic run_traffic(input int cycles, input int mode);
        gen_in_frame = 1'b0;
        repeat (cycles) begin
            step($urandom_range(7) != 0, mode);
        end
        repeat (3) begin
            step(1'b0, mode);
        end
    endtask

    //////////////////////////////////////////////////
    // Register port
    //////////////////////////////////////////////////

    task automatic reg_access(
        input  logic                              we,
        input  logic [rx_pcs_pkg::REG_ADDR_W-1:0] addr,
        input  logic [rx_pcs_pkg::REG_DATA_W-1:0] wdata,
        output logic [rx_pcs_pkg::REG_DATA_W-1:0] rdata
    );
        @(posedge rx_clk_161_13);
        #2;
        reg_req_i   = 1'b1;
        reg_we_i    = we;
        reg_addr_i  = addr;
        reg_wdata_i = wdata;
        do begin
            @(posedge rx_clk_161_13);
            #2;
        end while (reg_ack_o !== 1'b1);
        rdata     = reg_rdata_o;
        reg_req_i = 1'b0;
        do begin
            @(posedge rx_clk_161_13);
            #2;
        end while (reg_ack_o !== 1'b0);
    endtask

    task automatic write_reg(
        input logic [rx_pcs_pkg::REG_ADDR_W-1:0] addr,
        input logic [rx_pcs_pkg::REG_DATA_W-1:0] wdata
    );
        logic [rx_pcs_pkg::REG_DATA_W-1:0] ignored;
        reg_access(1'b1, addr, wdata, ignored);
        if (addr == rx_pcs_pkg::REG_ERRCNT) begin
            model_errcnt = '0;
        end else begin
            model_bypass = wdata[0];
        end
    endtask

    task automatic read_and_check(input logic [rx_pcs_pkg::REG_ADDR_W-1:0] addr);
        logic [rx_pcs_pkg::REG_DATA_W-1:0] rdata;
        logic [rx_pcs_pkg::REG_DATA_W-1:0] expected;
        expected = (addr == rx_pcs_pkg::REG_ERRCNT) ? rx_pcs_pkg::REG_DATA_W'(model_errcnt)
                                                     : rx_pcs_pkg::REG_DATA_W'(model_bypass);
        reg_access(1'b0, addr, '0, rdata);
        check_count(test_name, expected, rdata);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(22));
        async_reset_n  = 1'b0;
        block_valid_i  = 1'b0;
        rx_header_i    = '0;
        rx_data_i      = '0;
        reg_req_i      = 1'b0;
        reg_we_i       = 1'b0;
        reg_addr_i     = '0;
        reg_wdata_i    = '0;
        exp_valid      = 1'b0;
        exp_rxd        = '0;
        exp_rxc        = '0;
        gen_in_frame   = 1'b0;
        gen_data_left  = 0;
        model_in_frame = 1'b0;
        model_bypass   = 1'b0;
        model_errcnt   = '0;
        lane_errors    = 0;
        flag_errors    = 0;
        reg_errors     = 0;
        test_name      = "reset_count";
        repeat (5) @(posedge rx_clk_161_13);
        #2 async_reset_n = 1'b1;
        read_and_check(rx_pcs_pkg::REG_ERRCNT);

        test_name = "random_frames";
        run_traffic(RANDOM_CYCLES, MODE_MIXED);
        read_and_check(rx_pcs_pkg::REG_ERRCNT);

        test_name = "clear_count";
        write_reg(rx_pcs_pkg::REG_ERRCNT, 8'h00);
        read_and_check(rx_pcs_pkg::REG_ERRCNT);

        test_name = "saturation";
        run_traffic(SHORT_CYCLES, MODE_BAD);
        read_and_check(rx_pcs_pkg::REG_ERRCNT);
        write_reg(rx_pcs_pkg::REG_ERRCNT, 8'h00);

        test_name = "bypass";
        write_reg(rx_pcs_pkg::REG_CTRL, 8'h01);
        read_and_check(rx_pcs_pkg::REG_CTRL);
        run_traffic(SHORT_CYCLES, MODE_MIXED);
        read_and_check(rx_pcs_pkg::REG_ERRCNT);

        test_name = "after_bypass";
        write_reg(rx_pcs_pkg::REG_CTRL, 8'h00);
        run_traffic(SHORT_CYCLES, MODE_MIXED);
        read_and_check(rx_pcs_pkg::REG_ERRCNT);

        $display("Summary: %0d lane errors, %0d valid errors, %0d register errors",
                 lane_errors, flag_errors, reg_errors);
        if (lane_errors + flag_errors + reg_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: source/rx_pcs_lanes.sv
module rx_pcs_lanes (
    input  logic rx_clk_161_13,
    input  logic async_reset_n,

    // Blocks from the gearbox, lane 0 oldest
    input  logic                                                      block_valid_i,
    input  logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::HDR_W-1:0]  rx_header_i,
    input  logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] rx_data_i,

    // Host register port
    input  logic                              reg_req_i,
    input  logic                              reg_we_i,
    input  logic [rx_pcs_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [rx_pcs_pkg::REG_DATA_W-1:0] reg_wdata_i,

    // XGMII towards the MAC
    output logic                                                      xgmii_valid_o,
    output logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] xgmii_rxd_o,
    output logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::CTRL_W-1:0] xgmii_rxc_o,

    output logic                              reg_ack_o,
    output logic [rx_pcs_pkg::REG_DATA_W-1:0] reg_rdata_o
);

    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] dec_rxd;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::CTRL_W-1:0] dec_rxc;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::KIND_W-1:0] dec_kind;
    logic [rx_pcs_pkg::NUM_LANES-1:0]                          seq_err;
    logic                                                      bypass;
    logic [$clog2(rx_pcs_pkg::NUM_LANES+1)-1:0]                err_inc;

    //////////////////////////////////////////////////
    // Per-lane decoders
    //////////////////////////////////////////////////

    for (genvar g = 0; g < rx_pcs_pkg::NUM_LANES; g++) begin : g_lane
        block_decoder u_dec (
            .header_i  (rx_header_i[g]),
            .payload_i (rx_data_i[g]),
            .rxd_o     (dec_rxd[g]),
            .rxc_o     (dec_rxc[g]),
            .kind_o    (dec_kind[g])
        );
    end

    frame_sequence_check u_seq_check (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .block_valid_i (block_valid_i),
        .kind_i        (dec_kind),
        .seq_err_o     (seq_err)
    );

    xgmii_rx_output u_rx_output (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .block_valid_i (block_valid_i),
        .bypass_i      (bypass),
        .dec_rxd_i     (dec_rxd),
        .dec_rxc_i     (dec_rxc),
        .raw_data_i    (rx_data_i),
        .seq_err_i     (seq_err),
        .xgmii_valid_o (xgmii_valid_o),
        .xgmii_rxd_o   (xgmii_rxd_o),
        .xgmii_rxc_o   (xgmii_rxc_o),
        .err_inc_o     (err_inc)
    );

    rx_cfg_regs u_cfg_regs (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .err_inc_i     (err_inc),
        .reg_req_i     (reg_req_i),
        .reg_we_i      (reg_we_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .bypass_o      (bypass),
        .reg_ack_o     (reg_ack_o),
        .reg_rdata_o   (reg_rdata_o)
    );

endmodule

// File: source/rx_cfg_regs.sv
module rx_cfg_regs (
    input  logic                                       rx_clk_161_13,
    input  logic                                       async_reset_n,
    input  logic [$clog2(rx_pcs_pkg::NUM_LANES+1)-1:0] err_inc_i,
    input  logic                                       reg_req_i,
    input  logic                                       reg_we_i,
    input  logic [rx_pcs_pkg::REG_ADDR_W-1:0]          reg_addr_i,
    input  logic [rx_pcs_pkg::REG_DATA_W-1:0]          reg_wdata_i,
    output logic                                       bypass_o,
    output logic                                       reg_ack_o,
    output logic [rx_pcs_pkg::REG_DATA_W-1:0]          reg_rdata_o
);

    logic                            ack_q;
    logic                            bypass_q;
    logic [rx_pcs_pkg::ERRCNT_W-1:0] errcnt_q;
    logic [rx_pcs_pkg::ERRCNT_W:0]   cnt_sum;
    logic                            access;
    logic                            err_clear;

    // One access per request, on the cycle before ack rises
    assign access    = reg_req_i && !ack_q;
    assign err_clear = access && reg_we_i && (reg_addr_i == rx_pcs_pkg::REG_ERRCNT);

    //////////////////////////////////////////////////
    // Four-phase handshake and control bit
    //////////////////////////////////////////////////

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            ack_q    <= 1'b0;
            bypass_q <= 1'b0;
        end else begin
            if (access) begin
                ack_q <= 1'b1;
            end else if (!reg_req_i) begin
                ack_q <= 1'b0;
            end
            if (access && reg_we_i && (reg_addr_i == rx_pcs_pkg::REG_CTRL)) begin
                bypass_q <= reg_wdata_i[0];
            end
        end
    end

    // Saturating errored-block count
    assign cnt_sum = {1'b0, errcnt_q} + (rx_pcs_pkg::ERRCNT_W+1)'(err_inc_i);

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            errcnt_q <= '0;
        end else if (err_clear) begin
            errcnt_q <= '0;
        end else if (cnt_sum > rx_pcs_pkg::ERRCNT_MAX) begin
            errcnt_q <= rx_pcs_pkg::ERRCNT_MAX;
        end else begin
            errcnt_q <= cnt_sum[rx_pcs_pkg::ERRCNT_W-1:0];
        end
    end

    always_comb begin
        if (!ack_q) begin
            reg_rdata_o = '0;
        end else if (reg_addr_i == rx_pcs_pkg::REG_ERRCNT) begin
            reg_rdata_o = rx_pcs_pkg::REG_DATA_W'(errcnt_q);
        end else begin
            reg_rdata_o = rx_pcs_pkg::REG_DATA_W'(bypass_q);
        end
    end

    assign reg_ack_o = ack_q;
    assign bypass_o  = bypass_q;

    a_ack_needs_req : assert property (
        @(posedge rx_clk_161_13) disable iff (!async_reset_n)
        $rose(reg_ack_o) |-> $past(reg_req_i)
    ) else $error("rx_cfg_regs: ack raised without a request");

endmodule

// File: source/xgmii_rx_output.sv
module xgmii_rx_output (
    input  logic rx_clk_161_13,
    input  logic async_reset_n,
    input  logic block_valid_i,
    input  logic bypass_i,
    input  logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] dec_rxd_i,
    input  logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::CTRL_W-1:0] dec_rxc_i,
    input  logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] raw_data_i,
    input  logic [rx_pcs_pkg::NUM_LANES-1:0]                          seq_err_i,
    output logic                                                      xgmii_valid_o,
    output logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] xgmii_rxd_o,
    output logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::CTRL_W-1:0] xgmii_rxc_o,
    output logic [$clog2(rx_pcs_pkg::NUM_LANES+1)-1:0]                err_inc_o
);

    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::DATA_W-1:0] lane_rxd;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::CTRL_W-1:0] lane_rxc;
    logic [$clog2(rx_pcs_pkg::NUM_LANES+1)-1:0]                err_cnt;

    //////////////////////////////////////////////////
    // Error substitution and bypass
    //////////////////////////////////////////////////

    always_comb begin
        err_cnt = '0;
        for (int i = 0; i < rx_pcs_pkg::NUM_LANES; i++) begin
            if (bypass_i) begin
                lane_rxd[i] = raw_data_i[i];
                lane_rxc[i] = '0;
            end else if (seq_err_i[i]) begin
                lane_rxd[i] = {rx_pcs_pkg::CTRL_W{rx_pcs_pkg::XG_ERROR}};
                lane_rxc[i] = '1;
                err_cnt     = err_cnt + 1'b1;
            end else begin
                lane_rxd[i] = dec_rxd_i[i];
                lane_rxc[i] = dec_rxc_i[i];
            end
        end
    end

    // Output lanes only load on valid sets
    always_ff @(posedge rx_clk_161_13) begin
        if (block_valid_i) begin
            xgmii_rxd_o <= lane_rxd;
            xgmii_rxc_o <= lane_rxc;
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            xgmii_valid_o <= 1'b0;
            err_inc_o     <= '0;
        end else begin
            xgmii_valid_o <= block_valid_i;
            // Zero on gaps so the counter adds each set once
            err_inc_o     <= block_valid_i ? err_cnt : '0;
        end
    end

endmodule

// File: source/frame_sequence_check.sv
module frame_sequence_check (
    input  logic rx_clk_161_13,
    input  logic async_reset_n,
    input  logic block_valid_i,
    input  logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::KIND_W-1:0] kind_i,
    output logic [rx_pcs_pkg::NUM_LANES-1:0] seq_err_o
);

    logic [rx_pcs_pkg::KIND_W-1:0]                             prev_kind_q;
    logic [rx_pcs_pkg::NUM_LANES:0]                            in_frame;
    logic [rx_pcs_pkg::NUM_LANES-1:0]                          lane_err;
    logic [rx_pcs_pkg::NUM_LANES-1:0][rx_pcs_pkg::KIND_W-1:0] eff_kind;

    //////////////////////////////////////////////////
    // Walk lanes oldest to newest
    //////////////////////////////////////////////////

    always_comb begin
        in_frame[0] = (prev_kind_q == rx_pcs_pkg::KIND_START) ||
                      (prev_kind_q == rx_pcs_pkg::KIND_DATA);

        for (int i = 0; i < rx_pcs_pkg::NUM_LANES; i++) begin
            if (kind_i[i] == rx_pcs_pkg::KIND_BAD) begin
                lane_err[i] = 1'b1;
            end else if (in_frame[i]) begin
                lane_err[i] = (kind_i[i] == rx_pcs_pkg::KIND_START) ||
                              (kind_i[i] == rx_pcs_pkg::KIND_IDLE);
            end else begin
                lane_err[i] = (kind_i[i] == rx_pcs_pkg::KIND_DATA) ||
                              (kind_i[i] == rx_pcs_pkg::KIND_TERM);
            end

            // Flagged block drops the lane out of the frame
            eff_kind[i]   = lane_err[i] ? rx_pcs_pkg::KIND_IDLE : kind_i[i];
            in_frame[i+1] = (eff_kind[i] == rx_pcs_pkg::KIND_START) ||
                            (eff_kind[i] == rx_pcs_pkg::KIND_DATA);
        end
    end

    assign seq_err_o = block_valid_i ? lane_err : '0;

    // State carried from lane 3 into the next valid set
    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            prev_kind_q <= rx_pcs_pkg::KIND_IDLE;
        end else if (block_valid_i) begin
            prev_kind_q <= eff_kind[rx_pcs_pkg::NUM_LANES-1];
        end
    end

    a_no_err_when_idle : assert property (
        @(posedge rx_clk_161_13) disable iff (!async_reset_n)
        !block_valid_i |-> (seq_err_o == '0)
    ) else $error("frame_sequence_check: error flagged without valid blocks");

endmodule

// File: source/block_decoder.sv
module block_decoder (
    input  logic [rx_pcs_pkg::HDR_W-1:0]  header_i,
    input  logic [rx_pcs_pkg::DATA_W-1:0] payload_i,
    output logic [rx_pcs_pkg::DATA_W-1:0] rxd_o,
    output logic [rx_pcs_pkg::CTRL_W-1:0] rxc_o,
    output logic [rx_pcs_pkg::KIND_W-1:0] kind_o
);

    rx_pcs_pkg::block_payload_u blk;

    assign blk = payload_i;

    //////////////////////////////////////////////////
    // Block decode
    //////////////////////////////////////////////////

    always_comb begin
        // Anything not matched below stays an error block
        rxd_o  = {rx_pcs_pkg::CTRL_W{rx_pcs_pkg::XG_ERROR}};
        rxc_o  = '1;
        kind_o = rx_pcs_pkg::KIND_BAD;

        if (header_i == rx_pcs_pkg::SYNC_DATA) begin
            rxd_o  = blk.data;
            rxc_o  = '0;
            kind_o = rx_pcs_pkg::KIND_DATA;
        end else if (header_i == rx_pcs_pkg::SYNC_CTRL) begin
            case (blk.ctl.block_type)
                rx_pcs_pkg::BT_IDLE: begin
                    rxd_o  = {rx_pcs_pkg::CTRL_W{rx_pcs_pkg::XG_IDLE}};
                    rxc_o  = '1;
                    kind_o = rx_pcs_pkg::KIND_IDLE;
                end
                rx_pcs_pkg::BT_START: begin
                    // Start in lane 0, D1..D7 follow
                    rxd_o  = {blk.ctl.body, rx_pcs_pkg::XG_START};
                    rxc_o  = 8'h01;
                    kind_o = rx_pcs_pkg::KIND_START;
                end
                rx_pcs_pkg::BT_TERM7: begin
                    // Seven data bytes then terminate
                    rxd_o  = {rx_pcs_pkg::XG_TERM, blk.ctl.body};
                    rxc_o  = 8'h80;
                    kind_o = rx_pcs_pkg::KIND_TERM;
                end
                rx_pcs_pkg::BT_TERM0: begin
                    rxd_o  = {{(rx_pcs_pkg::CTRL_W-1){rx_pcs_pkg::XG_IDLE}},
                              rx_pcs_pkg::XG_TERM};
                    rxc_o  = '1;
                    kind_o = rx_pcs_pkg::KIND_TERM;
                end
                default: begin
                    rxd_o  = {rx_pcs_pkg::CTRL_W{rx_pcs_pkg::XG_ERROR}};
                    rxc_o  = '1;
                    kind_o = rx_pcs_pkg::KIND_BAD;
                end
            endcase
        end
    end

    // Data kind only ever comes from a data sync header
    always_comb begin
        assert (kind_o != rx_pcs_pkg::KIND_DATA || header_i == rx_pcs_pkg::SYNC_DATA)
            else $error("block_decoder: data kind without data header");
    end

endmodule

// File: source/rx_pcs_pkg.sv
package rx_pcs_pkg;

    //////////////////////////////////////////////////
    // Lanes and widths
    //////////////////////////////////////////////////

    localparam int NUM_LANES = 4;
    localparam int HDR_W     = 2;
    localparam int DATA_W    = 64;
    localparam int CTRL_W    = 8;

    // Sync headers
    localparam logic [HDR_W-1:0] SYNC_DATA = 2'b01;
    localparam logic [HDR_W-1:0] SYNC_CTRL = 2'b10;

    // Block type field of control blocks
    localparam logic [7:0] BT_IDLE  = 8'h1E;
    localparam logic [7:0] BT_START = 8'h78;
    localparam logic [7:0] BT_TERM7 = 8'hFF;
    localparam logic [7:0] BT_TERM0 = 8'h87;

    // XGMII control characters
    localparam logic [7:0] XG_IDLE  = 8'h07;
    localparam logic [7:0] XG_START = 8'hFB;
    localparam logic [7:0] XG_TERM  = 8'hFD;
    localparam logic [7:0] XG_ERROR = 8'hFE;

    // Block classification
    localparam int KIND_W = 3;
    localparam logic [KIND_W-1:0] KIND_DATA  = 3'd0;
    localparam logic [KIND_W-1:0] KIND_IDLE  = 3'd1;
    localparam logic [KIND_W-1:0] KIND_START = 3'd2;
    localparam logic [KIND_W-1:0] KIND_TERM  = 3'd3;
    localparam logic [KIND_W-1:0] KIND_BAD   = 3'd4;

    //////////////////////////////////////////////////
    // Errored-block counter and register map
    //////////////////////////////////////////////////

    localparam int ERRCNT_W = 8;
    localparam logic [ERRCNT_W-1:0] ERRCNT_MAX = 8'd255;

    localparam int REG_ADDR_W = 1;
    localparam int REG_DATA_W = 8;
    localparam logic [REG_ADDR_W-1:0] REG_ERRCNT = 1'b0;
    localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 1'b1;

    // Byte 0 sits in the low bits and goes first on the wire
    typedef union packed {
        logic [CTRL_W-1:0][7:0] data;
        struct packed {
            logic [55:0] body;
            logic [7:0]  block_type;
        } ctl;
    } block_payload_u;

endpackage
